// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv tb/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	$(SIM_BIN) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb.f ====
verilog/dcache_pkg.sv
verilog/sram_port_if.sv
verilog/way_sram.sv
verilog/tag_lookup.sv
verilog/line_datapath.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tb/mem_model.sv
tb/tb_dcache.sv

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// line-wide memory responder, 1 to 5 cycles per transfer
module mem_model (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              mem_valid,
    output logic              mem_ready,
    input  dcache_pkg::addr_t mem_addr,
    input  logic              mem_write,
    input  dcache_pkg::line_t mem_wline,
    output logic              mem_done,
    output dcache_pkg::line_t mem_rline
);
    import dcache_pkg::*;

    localparam int LOG_DEPTH = 64;

    line_t  store [line_addr_t];   // lines written back so far
    addr_t  wb_addr_log [LOG_DEPTH];
    line_t  wb_line_log [LOG_DEPTH];
    int     wb_count;
    integer seed;

    // every word differs, built from its full byte address
    function automatic word_t pattern_word(addr_t a);
        return {~a, a ^ 32'h3c5a_0f96};
    endfunction

    function automatic line_t fetch_line(addr_t base);
        line_t l;
        if (store.exists(base[31:OFFSET_BITS])) begin
            l = store[base[31:OFFSET_BITS]];
        end else begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                l[w] = pattern_word(base + 32'(w * 8));
            end
        end
        return l;
    endfunction

    initial begin
        int    lat;
        addr_t addr;
        logic  write;
        line_t wline;
        seed      = 82370;
        wb_count  = 0;
        mem_ready = 1'b0;
        mem_done  = 1'b0;
        mem_rline = '0;
        forever begin
            @(posedge clock);
            #1;
            if (reset_n && mem_valid) begin
                lat = 1 + int'($unsigned($random(seed)) % 5);
                repeat (lat - 1) begin
                    @(posedge clock);
                    #1;
                end
                addr      = mem_addr;   // payload held while valid waits
                write     = mem_write;
                wline     = mem_wline;
                mem_ready = 1'b1;
                @(posedge clock);
                #1;
                mem_ready = 1'b0;
                if (write) begin
                    store[addr[31:OFFSET_BITS]] = wline;
                    if (wb_count < LOG_DEPTH) begin
                        wb_addr_log[wb_count] = addr;
                        wb_line_log[wb_count] = wline;
                    end
                    wb_count++;
                end else begin
                    mem_rline = fetch_line(addr);
                end
                mem_done = 1'b1;
                @(posedge clock);
                #1;
                mem_done  = 1'b0;
                mem_rline = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int SET_BITS       = 4;
    localparam int REQUESTS       = 80;   // requests over all tests
    localparam int CYCLES_PER_REQ = 40;   // worst case with write-back and fetch
    localparam int CLOCK_NS       = 20;

    logic    clock;
    logic    reset_n;
    logic    req_valid;
    logic    req_ready;
    addr_t   req_addr;
    req_op_t req_op;
    word_t   req_wdata;
    word_t   req_wmask;
    logic    resp_done;
    word_t   resp_rdata;
    logic    mem_valid;
    logic    mem_ready;
    addr_t   mem_addr;
    logic    mem_write;
    line_t   mem_wline;
    logic    mem_done;
    line_t   mem_rline;

    word_t   shadow [addr_t];   // keyed by word address
    integer  seed;
    int      errors;
    int      errors_before;
    int      tests_run;
    int      tests_failed;

    dcache_top #(.SET_BITS(SET_BITS)) i_dut (
        .clock, .reset_n,
        .req_valid, .req_ready, .req_addr, .req_op, .req_wdata, .req_wmask,
        .resp_done, .resp_rdata,
        .mem_valid, .mem_ready, .mem_addr, .mem_write, .mem_wline, .mem_done, .mem_rline
    );

    mem_model i_mem (
        .clock, .reset_n,
        .mem_valid, .mem_ready, .mem_addr, .mem_write, .mem_wline, .mem_done, .mem_rline
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_NS / 2) clock = ~clock;
    end

    initial begin
        #((REQUESTS * CYCLES_PER_REQ + 20) * CLOCK_NS);
        $display("watchdog expired at %0t, tests did not finish", $time);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic word_t pattern_word(addr_t a);
        return {~a, a ^ 32'h3c5a_0f96};
    endfunction

    function automatic word_t expected_word(addr_t a);
        addr_t key;
        key = {a[31:3], 3'b000};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return pattern_word(key);
    endfunction

    function automatic void record_write(addr_t a, word_t data, word_t mask);
        word_t old;
        old = expected_word(a);
        shadow[{a[31:3], 3'b000}] = (old & ~mask) | (data & mask);
    endfunction

    function automatic void compare_word(string what, word_t got, word_t exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endfunction

    function automatic void expect_flag(string what, logic got, logic exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endfunction

    task automatic report_test(string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    // runs one whole request and checks read data against the shadow
    task automatic access(input req_op_t op, input addr_t addr, input word_t wdata,
                          input word_t wmask, output word_t rdata, output logic mem_seen);
        int cycles;
        cycles    = 0;
        mem_seen  = 1'b0;
        req_valid = 1'b1;
        req_addr  = addr;
        req_op    = op;
        req_wdata = wdata;
        req_wmask = wmask;
        while (!req_ready && cycles < CYCLES_PER_REQ) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        @(posedge clock);   // taken at this edge
        #1;
        req_valid = 1'b0;
        while (!resp_done && cycles < CYCLES_PER_REQ) begin
            mem_seen |= mem_valid;
            @(posedge clock);
            #1;
            cycles++;
        end
        rdata = resp_rdata;
        assert (resp_done) else begin
            $display("request at %h got no resp_done within %0d cycles", addr, cycles);
            errors++;
        end
        if (op == READ) begin
            compare_word($sformatf("resp_rdata at %h", addr), rdata, expected_word(addr));
        end else begin
            compare_word($sformatf("resp_rdata for write at %h", addr), rdata, '0);
            record_write(addr, wdata, wmask);
        end
        @(posedge clock);
        #1;
        expect_flag("resp_done one cycle later", resp_done, 1'b0);
    endtask

    task automatic check_reset_state();
        expect_flag("req_ready", req_ready, 1'b1);
        expect_flag("resp_done", resp_done, 1'b0);
        expect_flag("mem_valid", mem_valid, 1'b0);
        report_test("reset state");
    endtask

    task automatic read_miss_then_hit();
        word_t rdata;
        logic  mem_seen;
        access(READ, 32'h0000_1008, '0, '0, rdata, mem_seen);
        expect_flag("mem_valid during read miss", mem_seen, 1'b1);
        access(READ, 32'h0000_1030, '0, '0, rdata, mem_seen);   // same line
        expect_flag("mem_valid during read hit", mem_seen, 1'b0);
        report_test("read miss then hit");
    endtask

    task automatic masked_write_hit();
        word_t old, data, mask, rdata;
        logic  mem_seen;
        old  = expected_word(32'h0000_1010);
        data = 64'hdead_beef_0123_4567;
        mask = 64'h00ff_ff00_0000_ffff;
        access(WRITE, 32'h0000_1010, data, mask, rdata, mem_seen);
        expect_flag("mem_valid during write hit", mem_seen, 1'b0);
        access(READ, 32'h0000_1010, '0, '0, rdata, mem_seen);
        compare_word("resp_rdata after masked write at 00001010", rdata,
                     (old & ~mask) | (data & mask));
        report_test("masked write hit");
    endtask

    task automatic write_miss_allocate();
        word_t rdata;
        logic  mem_seen;
        access(WRITE, 32'h0000_2058, 64'h1111_2222_3333_4444, 64'hffff_0000_ffff_0000,
               rdata, mem_seen);
        expect_flag("mem_valid during write miss", mem_seen, 1'b1);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            access(READ, 32'h0000_2040 + 32'(w * 8), '0, '0, rdata, mem_seen);
        end
        report_test("write miss allocate");
    endtask

    // three lines 1 KB apart share set 5
    task automatic dirty_eviction();
        word_t rdata;
        logic  mem_seen;
        int    wb_before;
        addr_t base;
        wb_before = i_mem.wb_count;
        for (int l = 0; l < 3; l++) begin
            access(WRITE, 32'h0000_4148 + 32'(l * 'h400), 64'h5555_0000_0000_aaaa ^ 64'(l),
                   '1, rdata, mem_seen);
        end
        assert (i_mem.wb_count > wb_before) else begin
            $display("no dirty line was written back after three stores to one set");
            errors++;
        end
        for (int i = wb_before; i < i_mem.wb_count; i++) begin
            base = i_mem.wb_addr_log[i];
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                compare_word($sformatf("mem_wline word %0d at %h", w, base),
                             i_mem.wb_line_log[i][w], expected_word(base + 32'(w * 8)));
            end
        end
        for (int l = 0; l < 3; l++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                access(READ, 32'h0000_4140 + 32'(l * 'h400) + 32'(w * 8), '0, '0,
                       rdata, mem_seen);
            end
        end
        report_test("dirty eviction");
    endtask

    // 4 KB region is twice the cache size
    task automatic random_traffic();
        word_t   rdata, data, mask;
        logic    mem_seen;
        addr_t   a;
        req_op_t op;
        for (int n = 0; n < 40; n++) begin
            a    = 32'h0000_8000 + ($unsigned($random(seed)) & 32'h0000_0ff8);
            op   = ($random(seed) & 1) ? WRITE : READ;
            data = {$random(seed), $random(seed)};
            mask = {$random(seed), $random(seed)};
            access(op, a, data, mask, rdata, mem_seen);
        end
        report_test("random traffic");
    endtask

    initial begin
        seed          = 82370;
        errors        = 0;
        errors_before = 0;
        tests_run     = 0;
        tests_failed  = 0;
        reset_n       = 1'b0;
        req_valid     = 1'b0;
        req_addr      = '0;
        req_op        = READ;
        req_wdata     = '0;
        req_wmask     = '0;
        repeat (8) @(posedge clock);
        #1;
        reset_n = 1'b1;
        @(posedge clock);
        #1;
        check_reset_state();
        read_miss_then_hit();
        masked_write_hit();
        write_miss_allocate();
        dirty_eviction();
        random_traffic();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int SET_BITS = 9
) (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  dcache_pkg::addr_t                    req_addr,
    input  dcache_pkg::req_op_t                  req_op,
    input  dcache_pkg::word_t                    req_wdata,
    input  dcache_pkg::word_t                    req_wmask,
    output logic                                 resp_done,
    output dcache_pkg::word_t                    resp_rdata,
    output logic                                 mem_valid,
    input  logic                                 mem_ready,
    output dcache_pkg::addr_t                    mem_addr,
    output logic                                 mem_write,
    output dcache_pkg::line_t                    mem_wline,
    input  logic                                 mem_done,
    input  dcache_pkg::line_t                    mem_rline,
    output dcache_pkg::tag_op_t                  tag_op,
    output dcache_pkg::data_op_t                 data_op,
    output logic [SET_BITS-1:0]                  op_set,
    output dcache_pkg::line_addr_t               req_line,
    output logic [dcache_pkg::WORD_SEL_BITS-1:0] req_word_sel,
    output dcache_pkg::word_t                    req_data,
    output dcache_pkg::word_t                    req_mask,
    output logic                                 req_is_write,
    output dcache_pkg::way_oh_t                  use_way,
    input  logic                                 hit,
    input  dcache_pkg::way_oh_t                  hit_way,
    input  dcache_pkg::way_oh_t                  victim_way,
    input  logic                                 victim_dirty,
    input  dcache_pkg::line_addr_t               victim_addr,
    input  dcache_pkg::word_t                    read_word,
    input  dcache_pkg::line_t                    victim_line,
    output dcache_pkg::line_t                    mem_line
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WRITE_BACK,
        FETCH,
        REFILL
    } state_t;

    state_t     state;
    logic       accept;
    logic       hit_q;      // hit path, RESPOND does the store
    way_oh_t    way_q;      // hit way or chosen victim
    logic       mem_sent;   // request taken, waiting for mem_done
    line_addr_t wb_addr;
    word_t      resp_word;

    assign accept = req_valid && req_ready;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= IDLE;
            req_is_write <= 1'b0;
            hit_q        <= 1'b0;
            way_q        <= '0;
            mem_sent     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state        <= LOOKUP;
                        req_is_write <= (req_op == WRITE);
                    end
                end
                LOOKUP: begin
                    hit_q <= hit;
                    way_q <= hit ? hit_way : victim_way;   // lfsr moves on, so keep it
                    if (hit) begin
                        state <= RESPOND;
                    end else if (victim_dirty) begin
                        state <= WRITE_BACK;
                    end else begin
                        state <= FETCH;
                    end
                end
                WRITE_BACK: begin
                    if (mem_done) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (mem_done) begin
                        state <= REFILL;
                    end
                end
                REFILL:  state <= RESPOND;
                default: state <= IDLE;   // RESPOND
            endcase
            if (mem_done) begin
                mem_sent <= 1'b0;
            end else if (mem_valid && mem_ready) begin
                mem_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_line     <= req_addr[31:OFFSET_BITS];
            req_word_sel <= req_addr[OFFSET_BITS-1 -: WORD_SEL_BITS];
            req_data     <= req_wdata;
            req_mask     <= req_wmask;
        end
        if (state == LOOKUP) begin
            wb_addr   <= victim_addr;
            resp_word <= read_word;
        end
        if (state == FETCH && mem_done) begin
            mem_line <= mem_rline;   // rline is only valid on the done cycle
        end
        if (state == REFILL) begin
            resp_word <= read_word;
        end
    end

    always_comb begin
        tag_op  = TAG_NONE;
        data_op = DATA_NONE;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    tag_op  = TAG_READ;
                    data_op = DATA_READ;
                end
            end
            REFILL: begin
                tag_op  = req_is_write ? TAG_REFILL_DIRTY : TAG_REFILL_CLEAN;
                data_op = DATA_REFILL;
            end
            RESPOND: begin
                if (req_is_write && hit_q) begin
                    tag_op  = TAG_SET_DIRTY;
                    data_op = DATA_WRITE_WORD;
                end
            end
            default: begin
            end
        endcase
    end

    // the first read of a request uses the live address
    assign op_set  = (state == IDLE) ? req_addr[OFFSET_BITS +: SET_BITS] : req_line[SET_BITS-1:0];
    assign use_way = (state == LOOKUP) ? hit_way : way_q;

    assign req_ready  = (state == IDLE);
    assign resp_done  = (state == RESPOND);
    assign resp_rdata = (resp_done && !req_is_write) ? resp_word : '0;

    assign mem_valid = (state == WRITE_BACK || state == FETCH) && !mem_sent;
    assign mem_write = (state == WRITE_BACK);
    assign mem_addr  = {mem_write ? wb_addr : req_line, {OFFSET_BITS{1'b0}}};
    assign mem_wline = mem_write ? victim_line : '0;   // full victim line

endmodule

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] word_t;

    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_BITS    = 6;   // byte offset within a line
    localparam int WORD_SEL_BITS  = 3;   // address bits 5..3
    localparam int NUM_WAYS       = 2;

    // one line is eight word banks, bank 0 at the low end
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // full line address above the offset
    typedef logic [31-OFFSET_BITS:0] line_addr_t;

    typedef struct packed {
        logic       valid;
        logic       dirty;
        line_addr_t line;
    } tag_entry_t;

    typedef tag_entry_t [NUM_WAYS-1:0] tag_set_t;

    typedef logic [NUM_WAYS-1:0] way_oh_t;   // one-hot way select

    typedef enum logic {
        READ,
        WRITE
    } req_op_t;

    typedef enum logic [2:0] {
        TAG_NONE,
        TAG_READ,
        TAG_SET_DIRTY,
        TAG_REFILL_CLEAN,
        TAG_REFILL_DIRTY
    } tag_op_t;

    typedef enum logic [1:0] {
        DATA_NONE,
        DATA_READ,
        DATA_WRITE_WORD,
        DATA_REFILL
    } data_op_t;

    localparam logic [7:0] LFSR_SEED = 8'hFF;

endpackage

`default_nettype wire

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int SET_BITS = 9
) (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::req_op_t req_op,
    input  dcache_pkg::word_t   req_wdata,
    input  dcache_pkg::word_t   req_wmask,
    output logic                resp_done,
    output dcache_pkg::word_t   resp_rdata,
    output logic                mem_valid,
    input  logic                mem_ready,
    output dcache_pkg::addr_t   mem_addr,
    output logic                mem_write,
    output dcache_pkg::line_t   mem_wline,
    input  logic                mem_done,
    input  dcache_pkg::line_t   mem_rline
);
    import dcache_pkg::*;

    tag_op_t                  tag_op;
    data_op_t                 data_op;
    logic [SET_BITS-1:0]      op_set;
    line_addr_t               req_line;
    logic [WORD_SEL_BITS-1:0] req_word_sel;
    word_t                    req_data;
    word_t                    req_mask;
    logic                     req_is_write;
    way_oh_t                  use_way;
    logic                     hit;
    way_oh_t                  hit_way;
    way_oh_t                  victim_way;
    logic                     victim_dirty;
    line_addr_t               victim_addr;
    word_t                    read_word;
    line_t                    victim_line;
    line_t                    mem_line;

    sram_port_if #(.SET_BITS(SET_BITS), .entry_t(tag_entry_t)) tag_if ();
    sram_port_if #(.SET_BITS(SET_BITS), .entry_t(line_t))      data_if ();

    dcache_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (
        .clock, .reset_n,
        .req_valid, .req_ready, .req_addr, .req_op, .req_wdata, .req_wmask,
        .resp_done, .resp_rdata,
        .mem_valid, .mem_ready, .mem_addr, .mem_write, .mem_wline, .mem_done, .mem_rline,
        .tag_op, .data_op, .op_set, .req_line, .req_word_sel, .req_data, .req_mask,
        .req_is_write, .use_way, .hit, .hit_way, .victim_way, .victim_dirty,
        .victim_addr, .read_word, .victim_line, .mem_line
    );

    tag_lookup #(.SET_BITS(SET_BITS)) u_tag_lookup (
        .clock, .reset_n,
        .tag_op, .op_set, .req_line, .use_way,
        .tag_port (tag_if.requester),
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_addr
    );

    line_datapath #(.SET_BITS(SET_BITS)) u_line_datapath (
        .data_op, .op_set, .use_way,
        .word_sel (req_word_sel),
        .req_data, .req_mask, .req_is_write, .mem_line,
        .data_port (data_if.requester),
        .read_word, .victim_line
    );

    way_sram #(.SET_BITS(SET_BITS), .entry_t(tag_entry_t)) u_tag_sram (
        .clock, .reset_n,
        .port (tag_if.array)
    );

    way_sram #(.SET_BITS(SET_BITS), .entry_t(line_t)) u_data_sram (
        .clock, .reset_n,
        .port (data_if.array)
    );

endmodule

`default_nettype wire

// ==== verilog/line_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_datapath #(
    parameter int SET_BITS = 9
) (
    input  dcache_pkg::data_op_t                 data_op,
    input  logic [SET_BITS-1:0]                  op_set,
    input  dcache_pkg::way_oh_t                  use_way,
    input  logic [dcache_pkg::WORD_SEL_BITS-1:0] word_sel,
    input  dcache_pkg::word_t                    req_data,
    input  dcache_pkg::word_t                    req_mask,
    input  logic                                 req_is_write,
    input  dcache_pkg::line_t                    mem_line,
    sram_port_if.requester                       data_port,
    output dcache_pkg::word_t                    read_word,
    output dcache_pkg::line_t                    victim_line
);
    import dcache_pkg::*;

    line_t word_line;   // store word placed in its bank
    line_t word_mask;
    line_t fill_line;
    line_t way_line;

    always_comb begin
        word_line           = '0;
        word_mask           = '0;
        word_line[word_sel] = req_data;
        word_mask[word_sel] = req_mask;
    end

    // a store miss merges the new bits into the fetched line
    assign fill_line = req_is_write ? ((mem_line & ~word_mask) | (word_line & word_mask))
                                    : mem_line;

    assign way_line    = data_port.rdata[use_way[1]];
    assign victim_line = way_line;   // line handed out for write-back
    assign read_word   = (data_op == DATA_REFILL) ? mem_line[word_sel] : way_line[word_sel];

    always_comb begin
        data_port.ce     = (data_op == DATA_READ);
        data_port.set    = op_set;
        data_port.we_way = '0;
        data_port.wdata  = '0;
        data_port.wmask  = '0;
        case (data_op)
            DATA_WRITE_WORD: begin
                data_port.we_way = use_way;
                data_port.wdata  = word_line;
                data_port.wmask  = word_mask;   // only the addressed bank
            end
            DATA_REFILL: begin
                data_port.we_way = use_way;
                data_port.wdata  = fill_line;
                data_port.wmask  = '1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/sram_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one port into a two-way array, payload type set per instance
interface sram_port_if #(
    parameter int  SET_BITS = 9,
    parameter type entry_t  = logic
);
    import dcache_pkg::*;

    logic                       ce;       // read strobe
    way_oh_t                    we_way;   // per-way write enable
    logic [SET_BITS-1:0]        set;
    entry_t                     wdata;    // same data to every enabled way
    entry_t                     wmask;
    entry_t [NUM_WAYS-1:0]      rdata;    // both ways, held until next ce

    modport requester (
        output ce,
        output we_way,
        output set,
        output wdata,
        output wmask,
        input  rdata
    );

    modport array (
        input  ce,
        input  we_way,
        input  set,
        input  wdata,
        input  wmask,
        output rdata
    );

endinterface

`default_nettype wire

// ==== verilog/tag_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_lookup #(
    parameter int SET_BITS = 9
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  dcache_pkg::tag_op_t    tag_op,
    input  logic [SET_BITS-1:0]    op_set,
    input  dcache_pkg::line_addr_t req_line,
    input  dcache_pkg::way_oh_t    use_way,
    sram_port_if.requester         tag_port,
    output logic                   hit,
    output dcache_pkg::way_oh_t    hit_way,
    output dcache_pkg::way_oh_t    victim_way,
    output logic                   victim_dirty,
    output dcache_pkg::line_addr_t victim_addr
);
    import dcache_pkg::*;

    tag_set_t            tags;
    logic [NUM_WAYS-1:0] valid_vec;
    logic [7:0]          lfsr;
    tag_entry_t          vic_entry;
    tag_entry_t          use_entry;
    tag_entry_t          new_entry;

    assign tags = tag_port.rdata;

    // x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            valid_vec[w] = tags[w].valid;
            hit_way[w]   = tags[w].valid && (tags[w].line == req_line);
        end
    end

    assign hit = |hit_way;

    // first invalid way wins, random only when the set is full
    always_comb begin
        if (!valid_vec[0]) begin
            victim_way = 2'b01;
        end else if (!valid_vec[1]) begin
            victim_way = 2'b10;
        end else begin
            victim_way = lfsr[0] ? 2'b10 : 2'b01;
        end
    end

    assign vic_entry    = tags[victim_way[1]];
    assign victim_dirty = vic_entry.valid && vic_entry.dirty;
    assign victim_addr  = vic_entry.line;
    assign use_entry    = tags[use_way[1]];

    always_comb begin
        new_entry = use_entry;
        case (tag_op)
            TAG_SET_DIRTY: begin
                new_entry.dirty = 1'b1;
            end
            TAG_REFILL_CLEAN, TAG_REFILL_DIRTY: begin
                new_entry.valid = 1'b1;
                new_entry.dirty = (tag_op == TAG_REFILL_DIRTY);   // store miss
                new_entry.line  = req_line;
            end
            default: begin
            end
        endcase
    end

    assign tag_port.ce     = (tag_op == TAG_READ);
    assign tag_port.set    = op_set;
    assign tag_port.we_way = (tag_op inside {TAG_SET_DIRTY, TAG_REFILL_CLEAN, TAG_REFILL_DIRTY})
                           ? use_way : '0;
    assign tag_port.wdata  = new_entry;
    assign tag_port.wmask  = '1;   // whole entry on every tag write

endmodule

`default_nettype wire

// ==== verilog/way_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module way_sram #(
    parameter int  SET_BITS = 9,
    parameter type entry_t  = logic
) (
    input  logic      clock,
    input  logic      reset_n,
    sram_port_if.array port
);
    import dcache_pkg::*;

    localparam int DEPTH = 1 << SET_BITS;

    entry_t mem [NUM_WAYS][DEPTH];

    // stored entries are swept to zero on reset so every tag starts invalid
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                for (int s = 0; s < DEPTH; s++) begin
                    mem[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (port.we_way[w]) begin
                    mem[w][port.set] <= (mem[w][port.set] & ~port.wmask)
                                      | (port.wdata & port.wmask);
                end
            end
        end
    end

    // both ways read together, output holds between strobes
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            port.rdata <= '0;
        end else if (port.ce) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                port.rdata[w] <= mem[w][port.set];
            end
        end
    end

endmodule

`default_nettype wire
